/* hw/csr_isa_pkg.sv */
`default_nettype none

package csr_isa_pkg;

    ////////////////////////////////////////////////////////////
    // Zicsr operations and privilege levels
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_RW   = 3'd1,
        OP_RS   = 3'd2,
        OP_RC   = 3'd3,
        OP_RWI  = 3'd4,
        OP_RSI  = 3'd5,
        OP_RCI  = 3'd6
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_USER       = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE    = 2'd3
    } priv_e;

    ////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////

    // funct3 and opcode select the Zicsr form
    localparam logic [31:0] CSR_INST_MASK  = 32'h0000_707f;
    localparam logic [31:0] CSRRW_INST     = 32'h0000_1073;
    localparam logic [31:0] CSRRS_INST     = 32'h0000_2073;
    localparam logic [31:0] CSRRC_INST     = 32'h0000_3073;
    localparam logic [31:0] CSRRWI_INST    = 32'h0000_5073;
    localparam logic [31:0] CSRRSI_INST    = 32'h0000_6073;
    localparam logic [31:0] CSRRCI_INST    = 32'h0000_7073;

    // Matched as whole words
    localparam logic [31:0] ECALL_INST     = 32'h0000_0073;
    localparam logic [31:0] MRET_INST      = 32'h3020_0073;

    ////////////////////////////////////////////////////////////
    // CSR addresses
    ////////////////////////////////////////////////////////////

    localparam logic [11:0] ADDR_MSTATUS   = 12'h300;
    localparam logic [11:0] ADDR_MTVEC     = 12'h305;
    localparam logic [11:0] ADDR_MSCRATCH  = 12'h340;
    localparam logic [11:0] ADDR_MEPC      = 12'h341;
    localparam logic [11:0] ADDR_MCAUSE    = 12'h342;
    localparam logic [11:0] ADDR_MTVAL     = 12'h343;
    localparam logic [11:0] ADDR_SATP      = 12'h180;

    // ECALL from U, S, M gives cause 8, 9, 11
    localparam logic [4:0]  CAUSE_ECALL_BASE = 5'd8;

    // mstatus fields
    localparam int MSTATUS_SUM_BIT  = 18;
    localparam int MSTATUS_MPP_LSB  = 11;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MIE_BIT  = 3;

endpackage

`default_nettype wire

/* hw/csr_pipe_pkg.sv */
`default_nettype none

package csr_pipe_pkg;

    // Decoded CSR request from the execute stage
    typedef struct packed {
        csr_isa_pkg::csr_op_e op;
        logic [11:0]          addr;
        logic [4:0]           zimm;
        logic                 ecall;
        logic                 mret;
        logic [31:0]          rs1;
    } csr_req_t;

    // Bit 1 of the forwardA code selects MEM and bit 0 selects WB
    typedef enum logic [1:0] {
        FWD_RF  = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } fwd_src_e;

    typedef enum logic [1:0] {
        WB_DMEM = 2'b00,
        WB_ALU  = 2'b01,
        WB_PC4  = 2'b10
    } wb_sel_e;

    // Forwarding candidates from later stages
    typedef struct packed {
        logic [31:0] mem_alu;
        logic [31:0] wb_dmem;
        logic [31:0] wb_alu;
        logic [31:0] wb_pc;
        wb_sel_e     wb_sel;
    } fwd_bus_t;

    typedef struct packed {
        logic        en;
        logic [11:0] addr;
        logic [31:0] data;
    } csr_wb_t;

    typedef struct packed {
        logic        valid;
        logic [11:0] addr;
        logic [31:0] data;
    } csr_shadow_t;

    // Zero cause means no trap
    typedef struct packed {
        logic [4:0]  cause;
        logic [31:0] pc;
        logic [31:0] inst;
    } trap_t;

    typedef struct packed {
        logic [31:0]         satp;
        csr_isa_pkg::priv_e  priv;
        logic                sum;
    } mmu_ctl_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } redirect_t;

endpackage

`default_nettype wire

/* hw/csr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_decode (
    input  logic [31:0]            inst,
    input  logic [31:0]            rs1,
    output csr_pipe_pkg::csr_req_t req
);

    logic [31:0]          masked;
    csr_isa_pkg::csr_op_e op;

    assign masked = inst & csr_isa_pkg::CSR_INST_MASK;

    // Zicsr form from funct3 and opcode
    always_comb begin
        case (masked)
            csr_isa_pkg::CSRRW_INST:  op = csr_isa_pkg::OP_RW;
            csr_isa_pkg::CSRRS_INST:  op = csr_isa_pkg::OP_RS;
            csr_isa_pkg::CSRRC_INST:  op = csr_isa_pkg::OP_RC;
            csr_isa_pkg::CSRRWI_INST: op = csr_isa_pkg::OP_RWI;
            csr_isa_pkg::CSRRSI_INST: op = csr_isa_pkg::OP_RSI;
            csr_isa_pkg::CSRRCI_INST: op = csr_isa_pkg::OP_RCI;
            default:                  op = csr_isa_pkg::OP_NONE;
        endcase
    end

    // Address sits in the I-type immediate, zimm in the rs1 field
    assign req.op    = op;
    assign req.addr  = inst[31:20];
    assign req.zimm  = inst[19:15];
    assign req.ecall = (inst == csr_isa_pkg::ECALL_INST);
    assign req.mret  = (inst == csr_isa_pkg::MRET_INST);
    assign req.rs1   = rs1;

endmodule

`default_nettype wire

/* hw/csr_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_exec (
    input  logic                      clk,
    input  logic                      rst,
    input  csr_pipe_pkg::csr_req_t    req,
    input  csr_pipe_pkg::fwd_src_e    fwd_sel,
    input  csr_pipe_pkg::fwd_bus_t    fwd,
    input  logic                      flush,
    output logic [11:0]               raddr,
    input  logic [31:0]               rdata,
    output logic                      ecall,
    output logic                      mret,
    output csr_pipe_pkg::csr_wb_t     result,
    output logic [31:0]               old_value
);

    logic [31:0] wb_value;
    logic [31:0] src;
    logic [31:0] zimm_ext;
    logic [31:0] old_data;
    logic [31:0] new_data;
    logic        op_valid;

    logic        ex_en_q;
    logic [11:0] ex_addr_q;
    logic [31:0] ex_data_q;
    logic [31:0] old_q;
    logic        mem_valid_q;
    logic [11:0] mem_addr_q;
    logic [31:0] mem_data_q;

    csr_pipe_pkg::csr_shadow_t ex_shadow;
    csr_pipe_pkg::csr_shadow_t mem_shadow;

    ////////////////////////////////////////////////////////////
    // rs1 forwarding
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (fwd.wb_sel)
            csr_pipe_pkg::WB_DMEM: wb_value = fwd.wb_dmem;
            csr_pipe_pkg::WB_ALU:  wb_value = fwd.wb_alu;
            default:               wb_value = fwd.wb_pc + 32'd4;
        endcase
    end

    // MEM has the younger value and wins when both bits are set
    always_comb begin
        if (fwd_sel[1]) begin
            src = fwd.mem_alu;
        end else if (fwd_sel[0]) begin
            src = wb_value;
        end else begin
            src = req.rs1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Old value bypass and read-modify-write
    ////////////////////////////////////////////////////////////

    assign raddr = req.addr;

    assign ex_shadow  = '{valid: ex_en_q, addr: ex_addr_q, data: ex_data_q};
    assign mem_shadow = '{valid: mem_valid_q, addr: mem_addr_q, data: mem_data_q};

    // Results not yet committed by writeback
    always_comb begin
        if (ex_shadow.valid && ex_shadow.addr == req.addr) begin
            old_data = ex_shadow.data;
        end else if (mem_shadow.valid && mem_shadow.addr == req.addr) begin
            old_data = mem_shadow.data;
        end else begin
            old_data = rdata;
        end
    end

    assign zimm_ext = {27'd0, req.zimm};

    always_comb begin
        case (req.op)
            csr_isa_pkg::OP_RW:  new_data = src;
            csr_isa_pkg::OP_RS:  new_data = old_data | src;
            csr_isa_pkg::OP_RC:  new_data = old_data & ~src;
            csr_isa_pkg::OP_RWI: new_data = zimm_ext;
            csr_isa_pkg::OP_RSI: new_data = old_data | zimm_ext;
            csr_isa_pkg::OP_RCI: new_data = old_data & ~zimm_ext;
            default:             new_data = old_data;
        endcase
    end

    assign op_valid = (req.op != csr_isa_pkg::OP_NONE) && !flush;

    assign ecall = req.ecall && !flush;
    assign mret  = req.mret && !flush;

    ////////////////////////////////////////////////////////////
    // EX result and MEM shadow
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_en_q     <= 1'b0;
            mem_valid_q <= 1'b0;
        end else begin
            ex_en_q     <= op_valid;
            mem_valid_q <= ex_shadow.valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        ex_addr_q  <= req.addr;
        ex_data_q  <= new_data;
        old_q      <= old_data;
        mem_addr_q <= ex_shadow.addr;
        mem_data_q <= ex_shadow.data;
    end

    assign result    = '{en: ex_en_q, addr: ex_addr_q, data: ex_data_q};
    assign old_value = old_q;

endmodule

`default_nettype wire

/* hw/csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_file #(
    parameter logic [31:0] RESET_MTVEC = 32'h0000_0000
) (
    input  logic                      clk,
    input  logic                      rst,
    input  csr_pipe_pkg::csr_wb_t     wb,
    input  logic [11:0]               raddr,
    output logic [31:0]               rdata,
    input  csr_pipe_pkg::trap_t       trap,
    input  logic                      ecall,
    input  logic                      mret,
    output csr_pipe_pkg::redirect_t   redirect,
    output csr_pipe_pkg::mmu_ctl_t    mmu
);

    logic [31:0] mstatus_q;
    logic [31:0] mtvec_q;
    logic [31:0] mepc_q;
    logic [31:0] mcause_q;
    logic [31:0] mtval_q;
    logic [31:0] mscratch_q;
    logic [31:0] satp_q;

    csr_isa_pkg::priv_e priv_q;
    csr_isa_pkg::priv_e mpp;

    logic        trap_take;
    logic        ecall_take;
    logic        mret_take;
    logic [4:0]  cause_code;
    logic [31:0] trap_status;
    logic [31:0] mret_status;

    ////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (raddr)
            csr_isa_pkg::ADDR_MSTATUS:  rdata = mstatus_q;
            csr_isa_pkg::ADDR_MTVEC:    rdata = mtvec_q;
            csr_isa_pkg::ADDR_MEPC:     rdata = mepc_q;
            csr_isa_pkg::ADDR_MCAUSE:   rdata = mcause_q;
            csr_isa_pkg::ADDR_MTVAL:    rdata = mtval_q;
            csr_isa_pkg::ADDR_MSCRATCH: rdata = mscratch_q;
            csr_isa_pkg::ADDR_SATP:     rdata = satp_q;
            default:                    rdata = 32'd0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Trap, ECALL and MRET
    ////////////////////////////////////////////////////////////

    // Trap cause beats ECALL, ECALL beats MRET
    assign trap_take  = (trap.cause != 5'd0);
    assign ecall_take = !trap_take && ecall;
    assign mret_take  = !trap_take && !ecall && mret;

    assign cause_code = trap_take ? trap.cause
                                  : csr_isa_pkg::CAUSE_ECALL_BASE + {3'd0, priv_q};

    assign mpp = csr_isa_pkg::priv_e'(mstatus_q[csr_isa_pkg::MSTATUS_MPP_LSB +: 2]);

    // Entry stacks MIE and privilege
    always_comb begin
        trap_status = mstatus_q;
        trap_status[csr_isa_pkg::MSTATUS_MPP_LSB +: 2] = priv_q;
        trap_status[csr_isa_pkg::MSTATUS_MPIE_BIT]     = mstatus_q[csr_isa_pkg::MSTATUS_MIE_BIT];
        trap_status[csr_isa_pkg::MSTATUS_MIE_BIT]      = 1'b0;
    end

    // Return pops them and leaves MPP at user
    always_comb begin
        mret_status = mstatus_q;
        mret_status[csr_isa_pkg::MSTATUS_MPP_LSB +: 2] = csr_isa_pkg::PRIV_USER;
        mret_status[csr_isa_pkg::MSTATUS_MIE_BIT]      = mstatus_q[csr_isa_pkg::MSTATUS_MPIE_BIT];
        mret_status[csr_isa_pkg::MSTATUS_MPIE_BIT]     = 1'b1;
    end

    assign redirect.taken  = trap_take || ecall_take || mret_take;
    assign redirect.target = mret_take ? mepc_q : mtvec_q;

    ////////////////////////////////////////////////////////////
    // Register updates
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_q  <= 32'd0;
            mtvec_q    <= RESET_MTVEC;
            mepc_q     <= 32'd0;
            mcause_q   <= 32'd0;
            mtval_q    <= 32'd0;
            mscratch_q <= 32'd0;
            satp_q     <= 32'd0;
            priv_q     <= csr_isa_pkg::PRIV_MACHINE;
        end else begin
            if (wb.en) begin
                case (wb.addr)
                    csr_isa_pkg::ADDR_MSTATUS:  mstatus_q  <= wb.data;
                    csr_isa_pkg::ADDR_MTVEC:    mtvec_q    <= wb.data;
                    csr_isa_pkg::ADDR_MEPC:     mepc_q     <= wb.data;
                    csr_isa_pkg::ADDR_MCAUSE:   mcause_q   <= wb.data;
                    csr_isa_pkg::ADDR_MTVAL:    mtval_q    <= wb.data;
                    csr_isa_pkg::ADDR_MSCRATCH: mscratch_q <= wb.data;
                    csr_isa_pkg::ADDR_SATP:     satp_q     <= wb.data;
                    default: ;
                endcase
            end
            // Later assignments override a writeback to the same register
            if (trap_take || ecall_take) begin
                mepc_q    <= trap.pc;
                mtval_q   <= trap.inst;
                mcause_q  <= {27'd0, cause_code};
                mstatus_q <= trap_status;
                priv_q    <= csr_isa_pkg::PRIV_MACHINE;
            end else if (mret_take) begin
                mstatus_q <= mret_status;
                priv_q    <= mpp;
            end
        end
    end

    // MMU view
    assign mmu.satp = satp_q;
    assign mmu.priv = priv_q;
    assign mmu.sum  = mstatus_q[csr_isa_pkg::MSTATUS_SUM_BIT];

endmodule

`default_nettype wire

/* hw/csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
    parameter logic [31:0] RESET_MTVEC = 32'h0000_0000
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [31:0]               inst,
    input  logic [31:0]               rs1,
    input  csr_pipe_pkg::fwd_src_e    fwd_sel,
    input  csr_pipe_pkg::fwd_bus_t    fwd,
    input  logic                      flush,
    input  csr_pipe_pkg::csr_wb_t     wb,
    input  csr_pipe_pkg::trap_t       trap,
    output csr_pipe_pkg::csr_wb_t     result,
    output logic [31:0]               old_value,
    output csr_pipe_pkg::redirect_t   redirect,
    output csr_pipe_pkg::mmu_ctl_t    mmu
);

    csr_pipe_pkg::csr_req_t req;

    logic [11:0] raddr;
    logic [31:0] rdata;
    logic        ecall;
    logic        mret;

    csr_decode u_decode (
        .inst (inst),
        .rs1  (rs1),
        .req  (req)
    );

    csr_exec u_exec (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .fwd_sel   (fwd_sel),
        .fwd       (fwd),
        .flush     (flush),
        .raddr     (raddr),
        .rdata     (rdata),
        .ecall     (ecall),
        .mret      (mret),
        .result    (result),
        .old_value (old_value)
    );

    // Register file commits at writeback and owns trap control
    csr_file #(
        .RESET_MTVEC (RESET_MTVEC)
    ) u_file (
        .clk      (clk),
        .rst      (rst),
        .wb       (wb),
        .raddr    (raddr),
        .rdata    (rdata),
        .trap     (trap),
        .ecall    (ecall),
        .mret     (mret),
        .redirect (redirect),
        .mmu      (mmu)
    );

endmodule

`default_nettype wire

/* dv/csr_unit_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_unit_properties (
    input wire logic                    clk,
    input wire logic                    rst,
    input wire logic                    flush,
    input wire logic [31:0]             inst,
    input csr_pipe_pkg::trap_t          trap,
    input csr_pipe_pkg::csr_wb_t        result,
    input csr_pipe_pkg::redirect_t      redirect,
    input csr_pipe_pkg::mmu_ctl_t       mmu
);

    logic is_mret;

    // Failed assertions so far, summed into the end of run verdict
    int fail_count = 0;

    // Only a bare MRET returns since a trap cause takes precedence
    assign is_mret = (inst == csr_isa_pkg::MRET_INST) && (trap.cause == 5'd0);

    ////////////////////////////////////////////////////////////
    // Pipeline control
    ////////////////////////////////////////////////////////////

    flush_kills_result: assert property (
        @(posedge clk) disable iff (rst) flush |=> !result.en
    ) else begin
        $error("result.en high in the cycle after flush");
        fail_count++;
    end

    reset_clears_result: assert property (
        @(posedge clk) rst |=> !result.en
    ) else begin
        $error("result.en high after a reset edge");
        fail_count++;
    end

    // Trap entry always lands in machine mode
    redirect_enters_machine: assert property (
        @(posedge clk) disable iff (rst)
        (redirect.taken && !is_mret) |=> (mmu.priv == csr_isa_pkg::PRIV_MACHINE)
    ) else begin
        $error("privilege not machine after trap redirect");
        fail_count++;
    end

endmodule

bind csr_unit csr_unit_properties u_props (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .inst     (inst),
    .trap     (trap),
    .result   (result),
    .redirect (redirect),
    .mmu      (mmu)
);

`default_nettype wire

/* dv/csr_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;

    localparam logic [31:0] RESET_MTVEC = 32'h0000_0100;
    localparam logic [31:0] NOP_INST    = 32'h0000_0013;
    localparam int          MAX_STEPS   = 80;

    typedef struct {
        logic [31:0]               inst;
        logic [31:0]               rs1;
        csr_pipe_pkg::fwd_src_e    fwd_sel;
        csr_pipe_pkg::fwd_bus_t    fwd;
        logic                      flush;
        csr_pipe_pkg::trap_t       trap;
        int                        test;
        logic                      chk_old;
        csr_pipe_pkg::csr_wb_t     exp_res;
        logic [31:0]               exp_old;
        csr_pipe_pkg::redirect_t   exp_redir;
        csr_pipe_pkg::mmu_ctl_t    exp_mmu;
    } step_t;

    logic                      clk;
    logic                      rst;
    logic [31:0]               inst;
    logic [31:0]               rs1;
    csr_pipe_pkg::fwd_src_e    fwd_sel;
    csr_pipe_pkg::fwd_bus_t    fwd;
    logic                      flush;
    csr_pipe_pkg::csr_wb_t     wb;
    csr_pipe_pkg::trap_t       trap;
    csr_pipe_pkg::csr_wb_t     result;
    logic [31:0]               old_value;
    csr_pipe_pkg::redirect_t   redirect;
    csr_pipe_pkg::mmu_ctl_t    mmu;

    step_t steps [0:MAX_STEPS-1];
    int    n_steps;
    int    cur_test;
    int    errors;
    int    checks;
    int    test_err;
    int    cycles;
    int    limit;
    string names [1:6];

    // Reference model of committed state and in-flight shadows
    logic [31:0] m_mstatus, m_mtvec, m_mepc, m_mcause, m_mtval, m_mscratch, m_satp;
    csr_isa_pkg::priv_e        m_priv;
    csr_pipe_pkg::csr_shadow_t m_ex;
    csr_pipe_pkg::csr_shadow_t m_mem;

    csr_unit #(.RESET_MTVEC(RESET_MTVEC)) DUT (
        .clk (clk), .rst (rst), .inst (inst), .rs1 (rs1),
        .fwd_sel (fwd_sel), .fwd (fwd), .flush (flush), .wb (wb), .trap (trap),
        .result (result), .old_value (old_value), .redirect (redirect), .mmu (mmu)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycles <= cycles + 1;
        end
        if (limit > 0 && cycles > limit) begin
            $display("Timeout after %0d cycles, stimulus did not finish", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] model_read(logic [11:0] a);
        case (a)
            12'h300: return m_mstatus;
            12'h305: return m_mtvec;
            12'h341: return m_mepc;
            12'h342: return m_mcause;
            12'h343: return m_mtval;
            12'h340: return m_mscratch;
            12'h180: return m_satp;
            default: return 32'd0;
        endcase
    endfunction

    task automatic model_write(logic [11:0] a, logic [31:0] d);
        case (a)
            12'h300: m_mstatus  = d;
            12'h305: m_mtvec    = d;
            12'h341: m_mepc     = d;
            12'h342: m_mcause   = d;
            12'h343: m_mtval    = d;
            12'h340: m_mscratch = d;
            12'h180: m_satp     = d;
            default: ;
        endcase
    endtask

    function automatic logic [31:0] encode_csr(logic [2:0] f3, logic [11:0] a, logic [4:0] f);
        return {a, f, f3, 5'd1, 7'h73};
    endfunction

    function automatic csr_pipe_pkg::fwd_bus_t rand_fwd();
        csr_pipe_pkg::fwd_bus_t b;
        b.mem_alu = $urandom;
        b.wb_dmem = $urandom;
        b.wb_alu  = $urandom;
        b.wb_pc   = $urandom;
        b.wb_sel  = csr_pipe_pkg::wb_sel_e'(2'($urandom_range(0, 2)));
        return b;
    endfunction

    // Runs one step through the model and stores it with its expectations
    task automatic add_step(logic [31:0] i_inst, logic [31:0] i_rs1,
                            csr_pipe_pkg::fwd_src_e sel, csr_pipe_pkg::fwd_bus_t fb,
                            logic fl, csr_pipe_pkg::trap_t tp);
        step_t                 s;
        logic [2:0]            f3;
        logic [11:0]           a;
        logic [31:0]           wbv, src, old, nw, zimm;
        logic                  is_csr, ec, mr, tr;
        csr_pipe_pkg::csr_wb_t wbin;
        f3     = i_inst[14:12];
        a      = i_inst[31:20];
        zimm   = {27'd0, i_inst[19:15]};
        is_csr = (i_inst[6:0] == 7'h73) && (f3 != 3'd0) && (f3 != 3'd4);
        ec     = (i_inst == 32'h0000_0073) && !fl;
        mr     = (i_inst == 32'h3020_0073) && !fl;
        tr     = (tp.cause != 5'd0);
        case (fb.wb_sel)
            csr_pipe_pkg::WB_DMEM: wbv = fb.wb_dmem;
            csr_pipe_pkg::WB_ALU:  wbv = fb.wb_alu;
            default:               wbv = fb.wb_pc + 32'd4;
        endcase
        src = (sel == csr_pipe_pkg::FWD_MEM) ? fb.mem_alu :
              (sel == csr_pipe_pkg::FWD_WB)  ? wbv : i_rs1;
        if (m_ex.valid && m_ex.addr == a) old = m_ex.data;
        else if (m_mem.valid && m_mem.addr == a) old = m_mem.data;
        else old = model_read(a);
        case (f3)
            3'd1:    nw = src;
            3'd2:    nw = old | src;
            3'd3:    nw = old & ~src;
            3'd5:    nw = zimm;
            3'd6:    nw = old | zimm;
            3'd7:    nw = old & ~zimm;
            default: nw = old;
        endcase
        s.exp_redir.taken  = tr || ec || mr;
        s.exp_redir.target = (!tr && !ec && mr) ? m_mepc : m_mtvec;
        // At the clock edge writeback lands first and trap entry or return overrides it
        wbin = (n_steps >= 2) ? steps[n_steps-2].exp_res : '0;
        if (wbin.en) model_write(wbin.addr, wbin.data);
        if (tr || ec) begin
            m_mepc   = tp.pc;
            m_mtval  = tp.inst;
            m_mcause = tr ? {27'd0, tp.cause} : 32'd8 + {30'd0, m_priv};
            m_mstatus[12:11] = m_priv;
            m_mstatus[7]     = m_mstatus[3];
            m_mstatus[3]     = 1'b0;
            m_priv   = csr_isa_pkg::PRIV_MACHINE;
        end else if (mr) begin
            m_priv = csr_isa_pkg::priv_e'(m_mstatus[12:11]);
            m_mstatus[12:11] = 2'd0;
            m_mstatus[3]     = m_mstatus[7];
            m_mstatus[7]     = 1'b1;
        end
        m_mem = '{valid: m_ex.valid && !fl, addr: m_ex.addr, data: m_ex.data};
        m_ex  = '{valid: is_csr && !fl, addr: a, data: nw};
        s.inst    = i_inst;
        s.rs1     = i_rs1;
        s.fwd_sel = sel;
        s.fwd     = fb;
        s.flush   = fl;
        s.trap    = tp;
        s.test    = cur_test;
        s.chk_old = is_csr;
        s.exp_res = '{en: m_ex.valid, addr: a, data: nw};
        s.exp_old = old;
        s.exp_mmu = '{satp: m_satp, priv: m_priv, sum: m_mstatus[18]};
        steps[n_steps] = s;
        n_steps++;
    endtask

    task automatic csr_step(logic [2:0] f3, logic [11:0] a, logic [4:0] f, logic [31:0] v);
        add_step(encode_csr(f3, a, f), v, csr_pipe_pkg::FWD_RF, rand_fwd(), 1'b0, '0);
    endtask

    task automatic nop_steps(int n);
        for (int k = 0; k < n; k++) begin
            add_step(NOP_INST, $urandom, csr_pipe_pkg::FWD_RF, rand_fwd(), 1'b0, '0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic compare_wb(int idx, csr_pipe_pkg::csr_wb_t got, csr_pipe_pkg::csr_wb_t exp);
        checks++;
        if (got.en !== exp.en || (exp.en && got !== exp)) begin
            $display("FAIL step %0d result: got %h expected %h", idx, got, exp);
            errors++;
            test_err++;
        end
    endtask

    task automatic compare_word(int idx, string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL step %0d %s: got %h expected %h", idx, name, got, exp);
            errors++;
            test_err++;
        end
    endtask

    task automatic compare_redirect(int idx, csr_pipe_pkg::redirect_t got,
                                    csr_pipe_pkg::redirect_t exp);
        checks++;
        if (got.taken !== exp.taken || (exp.taken && got.target !== exp.target)) begin
            $display("FAIL step %0d redirect: got %h expected %h", idx, got, exp);
            errors++;
            test_err++;
        end
    endtask

    task automatic compare_mmu(int idx, csr_pipe_pkg::mmu_ctl_t got, csr_pipe_pkg::mmu_ctl_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL step %0d mmu: got %h expected %h", idx, got, exp);
            errors++;
            test_err++;
        end
    endtask

    task automatic check_outputs(int j);
        compare_wb(j, result, steps[j].exp_res);
        if (steps[j].chk_old) compare_word(j, "old_value", old_value, steps[j].exp_old);
        compare_mmu(j, mmu, steps[j].exp_mmu);
        if (j == n_steps - 1 || steps[j+1].test != steps[j].test) begin
            $display("test %0d %s: %0d errors", steps[j].test, names[steps[j].test], test_err);
            test_err = 0;
        end
    endtask

    task automatic drive(int i);
        inst    = steps[i].inst;
        rs1     = steps[i].rs1;
        fwd_sel = steps[i].fwd_sel;
        fwd     = steps[i].fwd;
        flush   = steps[i].flush;
        trap    = steps[i].trap;
        wb      = (i >= 2) ? steps[i-2].exp_res : '0;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////

    task automatic build_table();
        csr_pipe_pkg::fwd_bus_t fb;
        cur_test = 1;
        csr_step(3'd2, 12'h305, 5'd0, 32'd0);
        nop_steps(2);
        cur_test = 2;
        csr_step(3'd1, 12'h340, 5'd3, $urandom);
        nop_steps(2);
        csr_step(3'd2, 12'h340, 5'd4, $urandom);
        csr_step(3'd3, 12'h340, 5'd5, $urandom);
        csr_step(3'd5, 12'h340, 5'h15, $urandom);
        csr_step(3'd6, 12'h340, 5'h0a, $urandom);
        csr_step(3'd7, 12'h340, 5'h03, $urandom);
        csr_step(3'd1, 12'h7c0, 5'd6, $urandom);
        nop_steps(2);
        csr_step(3'd2, 12'h7c0, 5'd0, 32'd0);
        nop_steps(2);
        cur_test = 3;
        fb = rand_fwd();
        add_step(encode_csr(3'd1, 12'h340, 5'd7), $urandom, csr_pipe_pkg::FWD_MEM, fb, 1'b0, '0);
        for (int k = 0; k < 3; k++) begin
            fb = rand_fwd();
            fb.wb_sel = csr_pipe_pkg::wb_sel_e'(2'(k));
            add_step(encode_csr(3'd1, 12'h340, 5'd7), $urandom, csr_pipe_pkg::FWD_WB, fb, 1'b0,
                     '0);
        end
        nop_steps(2);
        cur_test = 4;
        csr_step(3'd1, 12'h340, 5'd8, $urandom);
        csr_step(3'd2, 12'h340, 5'd9, $urandom);
        nop_steps(1);
        csr_step(3'd2, 12'h340, 5'd0, 32'd0);
        nop_steps(2);
        add_step(encode_csr(3'd1, 12'h340, 5'd8), $urandom, csr_pipe_pkg::FWD_RF, rand_fwd(),
                 1'b1, '0);
        csr_step(3'd2, 12'h340, 5'd0, 32'd0);
        nop_steps(2);
        cur_test = 5;
        add_step(32'h3020_0073, 32'd0, csr_pipe_pkg::FWD_RF, rand_fwd(), 1'b0, '0);
        nop_steps(1);
        add_step(32'h0000_0073, 32'd0, csr_pipe_pkg::FWD_RF, rand_fwd(), 1'b0,
                 '{cause: 5'd0, pc: 32'h0000_2040, inst: 32'h0000_0073});
        csr_step(3'd2, 12'h341, 5'd0, 32'd0);
        csr_step(3'd2, 12'h342, 5'd0, 32'd0);
        csr_step(3'd2, 12'h343, 5'd0, 32'd0);
        add_step(32'h3020_0073, 32'd0, csr_pipe_pkg::FWD_RF, rand_fwd(), 1'b0, '0);
        nop_steps(1);
        add_step(NOP_INST, 32'd0, csr_pipe_pkg::FWD_RF, rand_fwd(), 1'b0,
                 '{cause: 5'd5, pc: 32'h0000_3300, inst: $urandom});
        csr_step(3'd2, 12'h342, 5'd0, 32'd0);
        csr_step(3'd2, 12'h343, 5'd0, 32'd0);
        csr_step(3'd2, 12'h300, 5'd0, 32'd0);
        nop_steps(1);
        cur_test = 6;
        csr_step(3'd1, 12'h180, 5'd2, $urandom);
        csr_step(3'd2, 12'h300, 5'd2, 32'h0004_0000);
        nop_steps(4);
    endtask

    initial begin
        void'($urandom(32'h9d33_7287));
        names[1] = "reset values";
        names[2] = "mscratch operations";
        names[3] = "rs1 forwarding";
        names[4] = "read bypass and flush";
        names[5] = "trap ecall mret";
        names[6] = "mmu outputs";
        errors = 0;
        checks = 0;
        test_err = 0;
        cycles = 0;
        limit = 0;
        n_steps = 0;
        rst = 1'b1;
        inst = NOP_INST;
        rs1 = 32'd0;
        fwd_sel = csr_pipe_pkg::FWD_RF;
        fwd = '0;
        flush = 1'b0;
        wb = '0;
        trap = '0;
        {m_mstatus, m_mepc, m_mcause, m_mtval, m_mscratch, m_satp} = '0;
        m_mtvec = RESET_MTVEC;
        m_priv = csr_isa_pkg::PRIV_MACHINE;
        m_ex = '0;
        m_mem = '0;
        build_table();
        limit = n_steps * 4 + 100;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_steps; i++) begin
            @(negedge clk);
            if (i > 0) check_outputs(i - 1);
            drive(i);
            #2;
            compare_redirect(i, redirect, steps[i].exp_redir);
        end
        @(negedge clk);
        check_outputs(n_steps - 1);
        $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
                 DUT.u_props.fail_count);
        if (errors == 0 && DUT.u_props.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
hw/csr_isa_pkg.sv
hw/csr_pipe_pkg.sv
hw/csr_decode.sv
hw/csr_exec.sv
hw/csr_file.sv
hw/csr_unit.sv
dv/csr_unit_properties.sv
dv/csr_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert \
    --top-module csr_unit_tb \
    -Mdir "$BUILD_DIR" \
    -f files.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/Vcsr_unit_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
